//--- address_decoder.sv
// purely combinational; rom_bank is only meaningful while the address is in 8000-bfff
`timescale 1ns/100ps
`default_nettype none

module address_decoder (
  input  logic [coco_pkg::addr_w-1:0] cpu_addr,
  input  coco_pkg::machine_e          machine,
  input  logic                        rom_bank_alt,
  output coco_pkg::device_e           device,
  output coco_pkg::rom_bank_e         rom_bank
);

  logic [coco_pkg::addr_w-1:0] rom_off;  // offset into the 16 KB rom window
  logic                        bas_half;

  assign rom_off  = cpu_addr - coco_pkg::rom_ext_base;
  assign bas_half = rom_off[coco_pkg::rom_aw];  // upper 8 KB holds basic

  // address compare chain, lowest region first
  always_comb
  begin
    if (cpu_addr <= coco_pkg::ram_top)
      device = coco_pkg::dev_ram;
    else if (cpu_addr < coco_pkg::rom_bas_base)
      device = coco_pkg::dev_rom_ext;
    else if (cpu_addr < coco_pkg::cart_base)
      device = coco_pkg::dev_rom_bas;
    else if (cpu_addr < coco_pkg::io_page)
      device = coco_pkg::dev_cart;
    else if (cpu_addr < coco_pkg::pia1_base)
    begin
      // d64 splits this page, a2 high reaches the acia
      if (machine == coco_pkg::mach_dragon64 && cpu_addr[2])
        device = coco_pkg::dev_none;
      else
        device = coco_pkg::dev_pia0;
    end
    else if (cpu_addr < coco_pkg::io_base)
      device = coco_pkg::dev_pia1;
    else if (cpu_addr < coco_pkg::unused_base)
      device = coco_pkg::dev_io;
    else
      device = coco_pkg::dev_none;
  end

  always_comb
  begin
    case (machine)
      coco_pkg::mach_dragon:
        rom_bank = bas_half ? coco_pkg::dragon_bas : coco_pkg::dragon_ext;
      coco_pkg::mach_dragon64:
        if (rom_bank_alt)  // second 16 KB rom chip
          rom_bank = bas_half ? coco_pkg::d64_alt_bas : coco_pkg::d64_alt_ext;
        else
          rom_bank = bas_half ? coco_pkg::d64_bas : coco_pkg::d64_ext;
      default:
        rom_bank = bas_half ? coco_pkg::coco_bas : coco_pkg::coco_ext;
    endcase
  end

endmodule

`default_nettype wire

//--- cart_store.sv
// download index 1 only; only ioctl_addr[13:0] reaches the store so larger images wrap
`timescale 1ns/100ps
`default_nettype none

module cart_store (
  input  logic                         clk,
  input  logic                         reset_n,
  input  logic                         access,
  input  logic                         cart_sel,
  input  logic [coco_pkg::cart_aw-1:0] cpu_addr_lo,
  output logic [coco_pkg::data_w-1:0]  rd_data,
  input  logic                         ioctl_wr,
  input  logic [coco_pkg::addr_w-1:0]  ioctl_addr,
  input  logic [coco_pkg::data_w-1:0]  ioctl_data,
  input  logic                         ioctl_download,
  input  logic                         ioctl_index,
  output logic                         cart_loaded
);

  logic [coco_pkg::data_w-1:0] mem [2**coco_pkg::cart_aw];

  // download side, write only
  always_ff @(posedge clk)
  begin
    if (ioctl_wr && ioctl_index)
      mem[ioctl_addr[coco_pkg::cart_aw-1:0]] <= ioctl_data;
  end

  // cpu side, synchronous read
  always_ff @(posedge clk)
  begin
    if (access && cart_sel)
      rd_data <= mem[cpu_addr_lo];
  end

  // tiny downloads leave the slot empty
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      cart_loaded <= 1'b0;
    else if (ioctl_download && !ioctl_wr && ioctl_index)
      cart_loaded <= (ioctl_addr > coco_pkg::cart_loaded_min);
  end

endmodule

`default_nettype wire

//--- clock_enable_gen.sv
// a change of turbo is only picked up at the next enable pulse; no enable on the first clock out of reset
`timescale 1ns/100ps
`default_nettype none

module clock_enable_gen (
  input  logic clk,
  input  logic reset_n,
  input  logic turbo,
  output logic cpu_ena
);

  logic [1:0] cnt;
  logic       turbo_q;  // period in force for the current bus cycle
  logic [1:0] last;

  assign last = turbo_q ? 2'(coco_pkg::div_turbo - 1) : 2'(coco_pkg::div_normal - 1);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      cnt     <= '0;
      turbo_q <= 1'b0;
      cpu_ena <= 1'b0;
    end
    else if (cnt == last)
    begin
      cnt     <= '0;
      turbo_q <= turbo;  // new speed from here on
      cpu_ena <= 1'b1;
    end
    else
    begin
      cnt     <= cnt + 2'd1;
      cpu_ena <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- coco_bus_assertions.sv
// bus timing only, data values are left to the testbench; bound into the top level
`timescale 1ns/100ps
`default_nettype none

module coco_bus_assertions (
  input logic clk,
  input logic reset_n,
  input logic cpu_ena,
  input logic access,
  input logic rd_valid
);

  // one clock wide at both speeds
  ena_single: assert property (@(posedge clk) disable iff (!reset_n) cpu_ena |=> !cpu_ena)
    else $error("cpu_ena high two cycles in a row");

  // data return only right after a taken bus cycle
  read_after_access: assert property (@(posedge clk) disable iff (!reset_n)
    rd_valid |-> $past(access))
    else $error("rd_valid without an access one clock before");

  idle_in_reset: assert property (@(posedge clk) !reset_n |=> !rd_valid)
    else $error("rd_valid high during reset");

endmodule

bind coco_bus_top coco_bus_assertions asrt_i (
  .clk      (clk),
  .reset_n  (reset_n),
  .cpu_ena  (cpu_ena),
  .access   (access),
  .rd_valid (rd_valid)
);

`default_nettype wire

//--- coco_bus_tb.sv
// acts as the cpu; rom data comes from a hashed model and cart cells are read only after a download
`timescale 1ns/100ps
`default_nettype none

module coco_bus_tb;

  logic                        clk;
  logic                        reset_n;
  logic                        turbo;
  coco_pkg::machine_e          machine;
  logic                        cpu_req;
  logic [coco_pkg::addr_w-1:0] cpu_addr;
  logic                        cpu_rw;
  logic [coco_pkg::data_w-1:0] cpu_wdata;
  logic                        cpu_ena;
  logic [coco_pkg::data_w-1:0] rd_data;
  logic                        rd_valid;
  coco_pkg::rom_bank_e         rom_bank;
  logic [coco_pkg::rom_aw-1:0] rom_addr;
  logic [coco_pkg::data_w-1:0] rom_rdata;
  logic                        ioctl_wr;
  logic [coco_pkg::addr_w-1:0] ioctl_addr;
  logic [coco_pkg::data_w-1:0] ioctl_data;
  logic                        ioctl_download;
  logic                        ioctl_index;
  logic                        cart_loaded;
  logic [4:0]                  vdg_mode;
  logic                        sound_bit;

  logic [31:0]         rng;  // xorshift state
  logic [7:0]          ram_sh [2**coco_pkg::ram_aw];  // shadow of system ram
  logic [7:0]          cart_sh [2**coco_pkg::cart_aw];
  logic [7:0]          pb_sh;
  logic [7:0]          ddr_sh;
  logic [7:0]          ctrl_sh;
  logic [7:0]          exp_data_q [$];  // one entry per read in flight
  coco_pkg::rom_bank_e exp_bank_q [$];
  logic                exp_rom_q [$];
  logic [7:0]          exp_d;
  coco_pkg::rom_bank_e exp_b;
  logic                exp_r;

  coco_bus_top dut_i (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // rom image, every bank and address hashed from seed 28
  function automatic logic [7:0] rom_model(input coco_pkg::rom_bank_e bank,
                                           input logic [12:0] addr);
    logic [31:0] x;
    x = xorshift(32'd28 ^ {13'd0, bank, addr, 3'd5});
    x = xorshift(x);
    return x[7:0] ^ x[23:16];
  endfunction

  assign rom_rdata = rom_model(rom_bank, rom_addr);  // outside rom answers at once

  // bank from machine, half and the d64 pb2 swap
  function automatic coco_pkg::rom_bank_e bank_for(input logic [15:0] addr);
    coco_pkg::rom_bank_e b;
    logic                bas;
    logic                alt;
    bas = (addr >= 16'ha000);
    alt = ddr_sh[2] & ~pb_sh[2];  // output driven low
    if (machine == coco_pkg::mach_dragon)
      b = bas ? coco_pkg::dragon_bas : coco_pkg::dragon_ext;
    else if (machine == coco_pkg::mach_dragon64 && alt)
      b = bas ? coco_pkg::d64_alt_bas : coco_pkg::d64_alt_ext;
    else if (machine == coco_pkg::mach_dragon64)
      b = bas ? coco_pkg::d64_bas : coco_pkg::d64_ext;
    else
      b = bas ? coco_pkg::coco_bas : coco_pkg::coco_ext;
    return b;
  endfunction

  // expected read value from the shadows and the memory map
  function automatic logic [7:0] ref_read(input logic [15:0] addr);
    logic [7:0] d;
    if (addr < 16'h8000)
      d = ram_sh[addr[14:0]];
    else if (addr < 16'hc000)
      d = rom_model(bank_for(addr), addr[12:0]);
    else if (addr < 16'hff00)
      d = cart_sh[addr[13:0]];
    else if (addr >= 16'hff20 && addr < 16'hff40)
    begin
      case (addr[1:0])
        2'd2:    d = ctrl_sh[2] ? pb_sh : ddr_sh;  // cr2 picks data reg
        2'd3:    d = ctrl_sh;
        default: d = 8'hff;  // port a side absent
      endcase
    end
    else
      d = 8'hff;  // pia0, acia, io, sam page
    return d;
  endfunction

  task automatic stop_run(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_data(input string name, input logic [7:0] got, input logic [7:0] exp);
    if (got !== exp)
      stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_bank(input string name, input coco_pkg::rom_bank_e got,
                            input coco_pkg::rom_bank_e exp);
    if (got !== exp)
      stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp)
      stop_run($sformatf("Fail %s got %h expected %h", name, got, exp));
  endtask

  task automatic tick();
    @(posedge clk);
    #1;  // drive and sample clear of the edge
  endtask

  task automatic wait_ena();
    int n;
    n = 0;
    while (!cpu_ena)
    begin
      tick();
      n++;
      if (n > 16)
        stop_run("timeout while waiting for cpu_ena");
    end
  endtask

  // request held until the clock after the taken enable
  task automatic bus_cycle(input logic [15:0] addr, input logic rw, input logic [7:0] wdata);
    cpu_addr  = addr;
    cpu_rw    = rw;
    cpu_wdata = wdata;
    cpu_req   = 1'b1;
    wait_ena();
    tick();  // access edge
    cpu_req = 1'b0;
    cpu_rw  = 1'b1;
  endtask

  task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
    if (addr < 16'h8000)
      ram_sh[addr[14:0]] = data;
    else if (addr >= 16'hff20 && addr < 16'hff40)
    begin
      if (addr[1:0] == 2'd3)
        ctrl_sh = data;
      else if (addr[1:0] == 2'd2 && ctrl_sh[2])
        pb_sh = data;
      else if (addr[1:0] == 2'd2)
        ddr_sh = data;
    end
    bus_cycle(addr, 1'b0, data);
  endtask

  task automatic bus_read(input logic [15:0] addr);
    exp_data_q.push_back(ref_read(addr));
    exp_bank_q.push_back(bank_for(addr));
    exp_rom_q.push_back(addr >= 16'h8000 && addr < 16'hc000);
    bus_cycle(addr, 1'b1, 8'h00);
  endtask

  // clocks from one enable pulse to the next, after the speed change has landed
  task automatic check_period(input logic t, input logic [7:0] exp);
    logic [7:0] cnt;
    turbo = t;
    wait_ena();
    tick();
    wait_ena();  // wrap that samples the new turbo
    tick();
    cnt = 8'd1;
    while (!cpu_ena)
    begin
      tick();
      cnt = cnt + 8'd1;
      if (cnt > 8'd16)
        stop_run("timeout while measuring the cpu_ena period");
    end
    check_data("cpu_ena period", cnt, exp);
  endtask

  task automatic rom_sweep(input coco_pkg::machine_e m);
    logic [31:0] r;
    machine = m;
    repeat (4)
    begin
      r = next_rand();
      bus_read({3'b100, r[12:0]});  // extended half
      bus_read({3'b101, r[28:16]});  // basic half
    end
  endtask

  // index 1 image from 0 up to last, then one idle cycle that closes it
  task automatic download(input logic [15:0] last);
    logic [31:0] r;
    int          a;
    ioctl_index    = 1'b1;
    ioctl_download = 1'b1;
    for (a = 0; a <= int'(last); a++)
    begin
      r          = next_rand();
      ioctl_addr = 16'(a);
      ioctl_data = r[7:0];
      ioctl_wr   = 1'b1;
      cart_sh[ioctl_addr[13:0]] = r[7:0];
      tick();
    end
    ioctl_wr = 1'b0;
    tick();  // size decision made here
    ioctl_download = 1'b0;
    ioctl_index    = 1'b0;
    tick();
    check_flag("cart_loaded", cart_loaded, last > 16'h0100);
  endtask

  // compare every returned read against the queue
  always @(negedge clk)
  begin
    if (reset_n && rd_valid)
    begin
      if (exp_data_q.size() == 0)
        stop_run("read data returned with no read pending");
      exp_d = exp_data_q.pop_front();
      exp_b = exp_bank_q.pop_front();
      exp_r = exp_rom_q.pop_front();
      check_data("rd_data", rd_data, exp_d);
      if (exp_r)
        check_bank("rom_bank", rom_bank, exp_b);
    end
  end

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  initial
  begin
    logic [15:0] addrs [12];
    logic [31:0] r;
    int          n;
    reset_n = 1'b0;
    turbo = 1'b0;
    machine = coco_pkg::mach_coco;
    cpu_req = 1'b0;
    cpu_addr = 16'h0000;
    cpu_rw = 1'b1;
    cpu_wdata = 8'h00;
    ioctl_wr = 1'b0;
    ioctl_addr = 16'h0000;
    ioctl_data = 8'h00;
    ioctl_download = 1'b0;
    ioctl_index = 1'b0;
    rng = 32'd28;
    pb_sh = 8'h00;
    ddr_sh = 8'h00;
    ctrl_sh = 8'h00;
    repeat (2) @(posedge clk);
    #1;
    reset_n = 1'b1;
    check_flag("cart_loaded", cart_loaded, 1'b0);
    check_data("vdg_mode", {3'b000, vdg_mode}, 8'h00);
    check_flag("sound_bit", sound_bit, 1'b0);

    check_period(1'b0, 8'd3);
    check_period(1'b1, 8'd2);

    foreach (addrs[i])
    begin
      r = next_rand();
      addrs[i] = {1'b0, r[14:0]};
      bus_write(addrs[i], r[23:16]);
    end
    foreach (addrs[i])
      bus_read(addrs[i]);
    bus_read(16'hff00);  // pia0
    bus_read(16'hff1c);
    bus_read(16'hff40);  // cartridge io
    bus_read(16'hff5f);
    bus_read(16'hff60);  // sam page
    bus_read(16'hfffe);

    rom_sweep(coco_pkg::mach_coco);
    rom_sweep(coco_pkg::mach_dragon);
    rom_sweep(coco_pkg::mach_dragon64);
    bus_read(16'hff04);  // d64 acia slot

    r = next_rand();
    bus_write(16'hff23, 8'h00);  // ddr selected
    bus_write(16'hff22, r[7:0] | 8'h04);
    bus_read(16'hff22);
    bus_write(16'hff23, 8'h04);
    bus_read(16'hff23);
    bus_write(16'hff22, 8'hfa);  // pb2 low, alt rom
    check_data("vdg_mode", {3'b000, vdg_mode}, {3'b000, pb_sh[7:3]});
    check_flag("sound_bit", sound_bit, pb_sh[1]);
    bus_read(16'hff3e);  // mirror of port b
    bus_read(16'hff20);
    bus_read(16'hff21);
    rom_sweep(coco_pkg::mach_dragon64);
    bus_write(16'hff22, 8'h24);  // pb2 high, back to normal rom
    check_data("vdg_mode", {3'b000, vdg_mode}, {3'b000, pb_sh[7:3]});
    check_flag("sound_bit", sound_bit, pb_sh[1]);
    rom_sweep(coco_pkg::mach_dragon64);

    download(16'h003f);  // too short to count as a cart
    repeat (4)
    begin
      r = next_rand();
      bus_read({10'b1100000000, r[5:0]});
    end
    download(16'h01ff);
    repeat (8)
    begin
      r = next_rand();
      bus_read({7'b1100000, r[8:0]});
    end

    n = 0;
    while (exp_data_q.size() != 0)
    begin
      tick();
      n++;
      if (n > 16)
        stop_run("timeout while waiting for the last read data");
    end
    $display("all tests passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- coco_bus_top.sv
// no cpu inside, the bus master must hold its request until the cycle after cpu_ena; roms are external
`timescale 1ns/100ps
`default_nettype none

module coco_bus_top (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        turbo,
  input  coco_pkg::machine_e          machine,
  input  logic                        cpu_req,
  input  logic [coco_pkg::addr_w-1:0] cpu_addr,
  input  logic                        cpu_rw,
  input  logic [coco_pkg::data_w-1:0] cpu_wdata,
  output logic                        cpu_ena,
  output logic [coco_pkg::data_w-1:0] rd_data,
  output logic                        rd_valid,
  output coco_pkg::rom_bank_e         rom_bank,
  output logic [coco_pkg::rom_aw-1:0] rom_addr,
  input  logic [coco_pkg::data_w-1:0] rom_rdata,
  input  logic                        ioctl_wr,
  input  logic [coco_pkg::addr_w-1:0] ioctl_addr,
  input  logic [coco_pkg::data_w-1:0] ioctl_data,
  input  logic                        ioctl_download,
  input  logic                        ioctl_index,
  output logic                        cart_loaded,
  output logic [4:0]                  vdg_mode,
  output logic                        sound_bit
);

  logic                        access;  // bus cycle actually taken
  coco_pkg::device_e           device;
  coco_pkg::rom_bank_e         rom_bank_dec;
  logic                        rom_bank_alt;
  logic [coco_pkg::data_w-1:0] regs_rdata;
  logic [coco_pkg::data_w-1:0] cart_rdata;

  assign access = cpu_ena & cpu_req;

  clock_enable_gen clk_en_i (
    .clk     (clk),
    .reset_n (reset_n),
    .turbo   (turbo),
    .cpu_ena (cpu_ena)
  );

  address_decoder dec_i (
    .cpu_addr     (cpu_addr),
    .machine      (machine),
    .rom_bank_alt (rom_bank_alt),
    .device       (device),
    .rom_bank     (rom_bank_dec)
  );

  sys_ctrl_regs regs_i (
    .clk          (clk),
    .reset_n      (reset_n),
    .access       (access),
    .pia1_hit     (device == coco_pkg::dev_pia1),
    .cpu_rw       (cpu_rw),
    .cpu_addr_lo  (cpu_addr[1:0]),
    .cpu_wdata    (cpu_wdata),
    .rd_data      (regs_rdata),
    .rom_bank_alt (rom_bank_alt),
    .vdg_mode     (vdg_mode),
    .sound_bit    (sound_bit)
  );

  cart_store cart_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .access         (access),
    .cart_sel       (device == coco_pkg::dev_cart),
    .cpu_addr_lo    (cpu_addr[coco_pkg::cart_aw-1:0]),
    .rd_data        (cart_rdata),
    .ioctl_wr       (ioctl_wr),
    .ioctl_addr     (ioctl_addr),
    .ioctl_data     (ioctl_data),
    .ioctl_download (ioctl_download),
    .ioctl_index    (ioctl_index),
    .cart_loaded    (cart_loaded)
  );

  ram_read_mux ram_i (
    .clk        (clk),
    .reset_n    (reset_n),
    .access     (access),
    .cpu_rw     (cpu_rw),
    .cpu_addr   (cpu_addr),
    .cpu_wdata  (cpu_wdata),
    .device     (device),
    .rom_bank   (rom_bank_dec),
    .cart_rdata (cart_rdata),
    .regs_rdata (regs_rdata),
    .rom_rdata  (rom_rdata),
    .rom_bank_q (rom_bank),
    .rom_addr   (rom_addr),
    .rd_data    (rd_data),
    .rd_valid   (rd_valid)
  );

endmodule

`default_nettype wire

//--- coco_pkg.sv
// bus widths and memory map are fixed by the machine; machine code 3 is not a valid machine
`default_nettype none

package coco_pkg;

  // bus and memory widths
  localparam int addr_w  = 16;
  localparam int data_w  = 8;
  localparam int ram_aw  = 15;  // 32 KB system ram
  localparam int cart_aw = 14;  // 16 KB cartridge window
  localparam int rom_aw  = 13;  // 8 KB per rom bank

  // memory map, sam style
  localparam logic [addr_w-1:0] ram_top      = 16'h7fff;
  localparam logic [addr_w-1:0] rom_ext_base = 16'h8000;  // extended basic
  localparam logic [addr_w-1:0] rom_bas_base = 16'ha000;  // colour basic
  localparam logic [addr_w-1:0] cart_base    = 16'hc000;
  localparam logic [addr_w-1:0] io_page      = 16'hff00;  // pia0 (and d64 acia)
  localparam logic [addr_w-1:0] pia1_base    = 16'hff20;
  localparam logic [addr_w-1:0] io_base      = 16'hff40;  // cartridge io
  localparam logic [addr_w-1:0] unused_base  = 16'hff60;  // sam regs and vectors, not mapped here

  localparam logic [data_w-1:0] unmapped_data   = 8'hff;  // floating bus reads high
  localparam logic [addr_w-1:0] cart_loaded_min = 16'h0100;

  localparam int bank_bit   = 2;  // pia1 port b / ddrb bit for the d64 rom swap
  localparam int div_normal = 3;  // clocks per bus cycle
  localparam int div_turbo  = 2;

  typedef enum logic [1:0] {
    mach_coco,
    mach_dragon,
    mach_dragon64
  } machine_e;

  // one select per 74ls138 output, acia slot folds into dev_none
  typedef enum logic [2:0] {
    dev_ram,
    dev_rom_ext,
    dev_rom_bas,
    dev_cart,
    dev_pia0,
    dev_pia1,
    dev_io,
    dev_none
  } device_e;

  typedef enum logic [2:0] {
    coco_ext,
    coco_bas,
    dragon_ext,
    dragon_bas,
    d64_ext,
    d64_bas,
    d64_alt_ext,
    d64_alt_bas
  } rom_bank_e;

endpackage

`default_nettype wire

//--- list.f
coco_pkg.sv
clock_enable_gen.sv
address_decoder.sv
sys_ctrl_regs.sv
cart_store.sv
ram_read_mux.sv
coco_bus_top.sv
coco_bus_assertions.sv
coco_bus_tb.sv

//--- ram_read_mux.sv
// rd_data is only valid while rd_valid is high; rom_rdata must answer in the cycle after the access
`timescale 1ns/100ps
`default_nettype none

module ram_read_mux (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        access,
  input  logic                        cpu_rw,
  input  logic [coco_pkg::addr_w-1:0] cpu_addr,
  input  logic [coco_pkg::data_w-1:0] cpu_wdata,
  input  coco_pkg::device_e           device,
  input  coco_pkg::rom_bank_e         rom_bank,
  input  logic [coco_pkg::data_w-1:0] cart_rdata,
  input  logic [coco_pkg::data_w-1:0] regs_rdata,
  input  logic [coco_pkg::data_w-1:0] rom_rdata,
  output coco_pkg::rom_bank_e         rom_bank_q,
  output logic [coco_pkg::rom_aw-1:0] rom_addr,
  output logic [coco_pkg::data_w-1:0] rd_data,
  output logic                        rd_valid
);

  logic [coco_pkg::data_w-1:0] ram [2**coco_pkg::ram_aw];
  logic [coco_pkg::data_w-1:0] ram_q;
  coco_pkg::device_e           dev_q;  // source of the pending read
  logic                        ram_sel;

  assign ram_sel = (device == coco_pkg::dev_ram);

  always_ff @(posedge clk)
  begin
    if (access && ram_sel && !cpu_rw)
      ram[cpu_addr[coco_pkg::ram_aw-1:0]] <= cpu_wdata;
    if (access && ram_sel)
      ram_q <= ram[cpu_addr[coco_pkg::ram_aw-1:0]];  // read before write
  end

  // capture what the return cycle needs
  always_ff @(posedge clk)
  begin
    if (access)
    begin
      dev_q      <= device;
      rom_bank_q <= rom_bank;
      rom_addr   <= cpu_addr[coco_pkg::rom_aw-1:0];
    end
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      rd_valid <= 1'b0;
    else
      rd_valid <= access & cpu_rw;  // one pulse per read
  end

  always_comb
  begin
    case (dev_q)
      coco_pkg::dev_ram:     rd_data = ram_q;
      coco_pkg::dev_rom_ext,
      coco_pkg::dev_rom_bas: rd_data = rom_rdata;  // external rom, same cycle
      coco_pkg::dev_cart:    rd_data = cart_rdata;
      coco_pkg::dev_pia1:    rd_data = regs_rdata;
      default:               rd_data = coco_pkg::unmapped_data;  // pia0, io, acia, gaps
    endcase
  end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f list.f --top-module coco_bus_tb -o coco_bus_sim
./obj_dir/coco_bus_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "all tests passed" sim.log; then
  echo "PASS"
else
  echo "FAIL"
  exit 1
fi

//--- sys_ctrl_regs.sv
// pia1 port b side only: no port a, no interrupt flags, outputs follow the data register not the ddr
`timescale 1ns/100ps
`default_nettype none

module sys_ctrl_regs (
  input  logic                        clk,
  input  logic                        reset_n,
  input  logic                        access,
  input  logic                        pia1_hit,
  input  logic                        cpu_rw,
  input  logic [1:0]                  cpu_addr_lo,
  input  logic [coco_pkg::data_w-1:0] cpu_wdata,
  output logic [coco_pkg::data_w-1:0] rd_data,
  output logic                        rom_bank_alt,
  output logic [4:0]                  vdg_mode,
  output logic                        sound_bit
);

  logic [coco_pkg::data_w-1:0] port_b;
  logic [coco_pkg::data_w-1:0] ddr_b;
  logic [coco_pkg::data_w-1:0] ctrl_b;
  logic [coco_pkg::data_w-1:0] rd_mux;
  logic                        wr_en;

  assign wr_en = access & pia1_hit & ~cpu_rw;

  always_comb
  begin
    case (cpu_addr_lo)
      2'd2:    rd_mux = ctrl_b[2] ? port_b : ddr_b;  // cr bit 2 picks data over ddr
      2'd3:    rd_mux = ctrl_b;
      default: rd_mux = coco_pkg::unmapped_data;  // port a not kept
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      port_b <= '0;
      ddr_b  <= '0;
      ctrl_b <= '0;
    end
    else if (wr_en)
    begin
      if (cpu_addr_lo == 2'd3)
        ctrl_b <= cpu_wdata;
      else if (cpu_addr_lo == 2'd2 && ctrl_b[2])
        port_b <= cpu_wdata;
      else if (cpu_addr_lo == 2'd2)
        ddr_b <= cpu_wdata;
    end
  end

  // read sampled at the access, old value on a same-cycle write
  always_ff @(posedge clk)
  begin
    if (access && pia1_hit && cpu_rw)
      rd_data <= rd_mux;
  end

  // pull-up on pb2 keeps the normal rom unless driven low as an output
  assign rom_bank_alt = ddr_b[coco_pkg::bank_bit] & ~port_b[coco_pkg::bank_bit];
  assign vdg_mode     = port_b[7:3];  // a/g, gm2..gm0, css
  assign sound_bit    = port_b[1];

endmodule

`default_nettype wire
